// ==== bench/fetch_asserts.sv ====
`default_nettype none

module fetch_asserts import fetch_pkg::*; (
	input wire      i_clock,
	input wire      i_reset,
	input wire      i_a_request,
	input wire      i_a_ready,
	input wire      i_b_request,
	input wire      i_b_ready,
	input wire      i_mem_request,
	input wire pc_t i_mem_address,
	input wire      i_mem_ready
);

	timeunit 1ns;
	timeprecision 100ps;

	int failures = 0;

	// The external request and its address hold until ready.
	mem_request_held: assert property (@(posedge i_clock) disable iff (i_reset)
		i_mem_request && !i_mem_ready |=> i_mem_request && $stable(i_mem_address))
	else begin
		$error("external request or address changed before ready");
		failures++;
	end

	// A port that waited while the other was served has the bus two cycles later.
	waiting_port_granted: assert property (@(posedge i_clock) disable iff (i_reset)
		(i_a_ready && i_b_request) || (i_b_ready && i_a_request) |-> ##2 i_mem_request)
	else begin
		$error("a waiting port was not granted the bus after the other port");
		failures++;
	end

	// A ready pulse only goes to a port that is requesting.
	ready_to_requester: assert property (@(posedge i_clock) disable iff (i_reset)
		(!i_a_ready || i_a_request) && (!i_b_ready || i_b_request))
	else begin
		$error("ready reached a port that was not requesting");
		failures++;
	end

endmodule

bind bus_arbiter fetch_asserts fetch_asserts_inst (
	.i_clock       (i_clock),
	.i_reset       (i_reset),
	.i_a_request   (port_a.request),
	.i_a_ready     (port_a.ready),
	.i_b_request   (port_b.request),
	.i_b_ready     (port_b.ready),
	.i_mem_request (mem.request),
	.i_mem_address (mem.address),
	.i_mem_ready   (mem.ready)
);

`default_nettype wire

// ==== bench/fetch_stim.txt ====
# op pc_a pc_b count step refills_a refills_b (refill totals after the line)
# ops: A, B, AB (both ports) or R (reset holding pc_a and pc_b)
A 00001000 00000000 1 0 2 1
A 00001000 00000000 4 0 2 1
A 00001004 00000000 7 4 9 1
A 00001000 00000000 8 4 9 1
A 00002000 00000000 1 0 10 1
A 00001000 00000000 1 0 11 1
A 00002000 00000000 1 0 12 1
A 00001000 00000000 1 0 13 1
B 00000000 00003000 1 0 13 2
B 00000000 00003004 3 4 13 5
B 00000000 00003000 4 4 13 5
AB 00004000 00005000 1 0 14 6
AB 00004004 00005004 4 4 18 10
AB 00004004 00005004 4 4 18 10
AB 00004000 00006000 2 0 18 11
R 00001000 00003000 0 0 1 1
A 00001004 00000000 1 0 2 1
B 00000000 00003004 1 0 2 2
AB 00004000 00005000 2 4 4 4
AB 00004000 00005000 2 4 4 4

// ==== bench/mem_model.sv ====
`default_nettype none

module mem_model import fetch_pkg::*; (
	input  wire      i_clock,
	input  wire      i_reset,
	input  wire      i_request,
	input  wire pc_t i_address,
	output logic     o_ready,
	output word_t    o_rdata
);

	timeunit 1ns;
	timeprecision 100ps;

	integer seed = 32'h6240_0f5c;
	integer draw;
	logic   busy;
	int     wait_left;

	initial begin
		o_ready = 1'b0;
		o_rdata = '0;
		busy = 1'b0;
		wait_left = 0;
	end

	// Accepts a request, then answers 1 to 4 falling edges later.
	always @(negedge i_clock) begin
		o_ready <= 1'b0;
		if (i_reset) begin
			busy <= 1'b0;
		end else if (busy) begin
			if (wait_left == 0) begin
				o_ready <= 1'b1;
				o_rdata <= {i_address[31:2], 2'b00} ^ 32'hA5A5_5A5A;
				busy <= 1'b0;
			end else begin
				wait_left <= wait_left - 1;
			end
		end else if (i_request && !o_ready) begin
			draw = $random(seed);
			wait_left <= draw & 3;
			busy <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== bench/tb_fetch.sv ====
`default_nettype none

module tb_fetch import fetch_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	logic        i_clock;
	logic        i_reset;
	pc_t         i_pc_a;
	pc_t         i_pc_b;
	logic        o_ready_a;
	logic        o_ready_b;
	word_t       o_rdata_a;
	word_t       o_rdata_b;
	logic [31:0] o_refills_a;
	logic [31:0] o_refills_b;
	logic        o_mem_request;
	pc_t         o_mem_address;
	logic        i_mem_ready;
	word_t       i_mem_rdata;

	// Reference model, one tag array per port.
	logic        model_valid [2][SETS];
	logic [23:0] model_tag [2][SETS];
	int          model_refills [2];

	int cycle_count = 0;
	int cycle_limit = 1000;

	fetch_top fetch_top_inst (.*);

	mem_model mem_model_inst (
		.i_clock   (i_clock),
		.i_reset   (i_reset),
		.i_request (o_mem_request),
		.i_address (o_mem_address),
		.o_ready   (i_mem_ready),
		.o_rdata   (i_mem_rdata)
	);

	initial begin
		i_clock = 1'b0;
		forever #10 i_clock = ~i_clock;
	end

	always @(posedge i_clock) begin
		cycle_count++;
		if (cycle_count > cycle_limit) begin
			plain_failure("the run did not finish within the cycle limit");
		end
		assert (fetch_top_inst.bus_arbiter_inst.fetch_asserts_inst.failures == 0)
		else plain_failure("a bus assertion failed");
	end

	task automatic plain_failure(input string why);
		$display("%s", why);
		$display("TEST FAIL");
		$fatal(1, "run stopped at the first failure");
	endtask

	task automatic value_mismatch(input string name, input logic [31:0] got,
			input logic [31:0] want);
		$display("[ERROR] %s is 0x%08h, expected 0x%08h", name, got, want);
		plain_failure("a checked value was wrong");
	endtask

	// Word address back to a byte address, XORed with the fill pattern.
	function automatic word_t expected_word(input pc_t pc);
		return {pc[31:2], 2'b00} ^ 32'hA5A5_5A5A;
	endfunction

	// Returns 1 on a predicted hit; a miss fills the line and counts a refill.
	function automatic logic model_hit(input int port, input pc_t pc);
		if (model_valid[port][pc[7:2]] && model_tag[port][pc[7:2]] == pc[31:8]) begin
			return 1'b1;
		end
		model_valid[port][pc[7:2]] = 1'b1;
		model_tag[port][pc[7:2]] = pc[31:8];
		model_refills[port]++;
		return 1'b0;
	endfunction

	// Drives both pcs and holds them until each selected port is ready.
	task automatic fetch_pair(input logic [1:0] sel, input pc_t pa, input pc_t pb,
			input logic fast);
		logic [1:0] hit;
		logic [1:0] seen;
		int         samples;
		int         p;
		word_t      got;
		pc_t        pc;
		i_pc_a = pa;
		i_pc_b = pb;
		for (p = 0; p < 2; p++) begin
			hit[p] = sel[p] ? model_hit(p, p ? pb : pa) : 1'b1;
		end
		seen = ~sel;
		samples = 0;
		while (seen != 2'b11) begin
			#1;
			samples++;
			// A request on the external bus carries the pc of a port still waiting.
			if (o_mem_request) begin
				assert ((!seen[0] && o_mem_address == pa) ||
					(!seen[1] && o_mem_address == pb))
				else value_mismatch("o_mem_address", o_mem_address, seen[0] ? pb : pa);
			end
			for (p = 0; p < 2; p++) begin
				pc = p ? pb : pa;
				got = p ? o_rdata_b : o_rdata_a;
				if (!seen[p] && (p ? o_ready_b : o_ready_a)) begin
					assert (got == expected_word(pc))
					else value_mismatch(p ? "o_rdata_b" : "o_rdata_a", got, expected_word(pc));
					assert (!fast || !hit[p] || samples == 1)
					else plain_failure("a sequential hit was not ready in its first cycle");
					seen[p] = 1'b1;
				end
			end
			if (seen != 2'b11) begin
				@(negedge i_clock);
			end
		end
	endtask

	// Reset with the given pcs held, watch the clear sweep, then fetch both pcs.
	task automatic apply_reset(input pc_t pa, input pc_t pb);
		int n;
		i_pc_a = pa;
		i_pc_b = pb;
		i_reset = 1'b1;
		repeat (10) @(negedge i_clock);
		i_reset = 1'b0;
		for (n = 0; n <= SETS; n++) begin
			#1;
			assert (!o_ready_a && !o_ready_b && !o_mem_request)
			else plain_failure("a ready or the memory request was high during the clear sweep");
			assert (o_refills_a == 0 && o_refills_b == 0)
			else plain_failure("the refill counters were not cleared by reset");
			@(negedge i_clock);
		end
		model_valid = '{default: '0};
		model_refills[0] = 0;
		model_refills[1] = 0;
		fetch_pair(2'b11, pa, pb, 1'b0);
	endtask

	initial begin
		int         fd;
		int         k;
		int         total;
		int         cnt;
		int         step;
		int         ea;
		int         eb;
		string      line;
		string      op;
		string      lines[$];
		pc_t        pa;
		pc_t        pb;
		logic [1:0] sel;
		i_reset = 1'b1;
		i_pc_a = '0;
		i_pc_b = '0;
		fd = $fopen("bench/fetch_stim.txt", "r");
		if (fd == 0) begin
			plain_failure("cannot open bench/fetch_stim.txt");
		end
		// The reset at the start counts as one fetch.
		total = 1;
		while ($fgets(line, fd) != 0) begin
			if ($sscanf(line, "%s %h %h %d %d %d %d", op, pa, pb, cnt, step, ea, eb) == 7) begin
				lines.push_back(line);
				total += (op == "R") ? 1 : cnt;
			end
		end
		$fclose(fd);
		cycle_limit = 40 * total + 200;
		@(negedge i_clock);
		apply_reset(32'h0, 32'h0);
		foreach (lines[i]) begin
			void'($sscanf(lines[i], "%s %h %h %d %d %d %d", op, pa, pb, cnt, step, ea, eb));
			if (op == "R") begin
				@(negedge i_clock);
				apply_reset(pa, pb);
			end else begin
				sel = {op == "B" || op == "AB", op == "A" || op == "AB"};
				for (k = 0; k < cnt; k++) begin
					@(negedge i_clock);
					fetch_pair(sel, sel[0] ? pa + 32'(k * step) : i_pc_a,
						sel[1] ? pb + 32'(k * step) : i_pc_b, k > 0 && step == 4);
				end
			end
			assert (model_refills[0] == ea && model_refills[1] == eb)
			else plain_failure("the reference model disagrees with the stimulus file counts");
			assert (o_refills_a == model_refills[0])
			else value_mismatch("o_refills_a", o_refills_a, model_refills[0]);
			assert (o_refills_b == model_refills[1])
			else value_mismatch("o_refills_b", o_refills_b, model_refills[1]);
		end
		if (fetch_top_inst.bus_arbiter_inst.fetch_asserts_inst.failures == 0) begin
			$display("TEST PASS");
			$finish;
		end else begin
			plain_failure("a bus assertion failed");
		end
	end

endmodule

`default_nettype wire

// ==== hw/bus_arbiter.sv ====
`default_nettype none

module bus_arbiter import fetch_pkg::*; (
	input  wire        i_clock,
	input  wire        i_reset,
	mem_bus_if.slave   port_a,
	mem_bus_if.slave   port_b,
	mem_bus_if.master  mem
);

	arb_state_t state;
	// Set when port B won the last grant, so port A goes first after reset.
	logic       last_b;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= ARB_IDLE;
			last_b <= 1'b1;
		end else begin
			case (state)
				ARB_IDLE: begin
					if (port_a.request && (!port_b.request || last_b)) begin
						state <= ARB_PORT_A;
						last_b <= 1'b0;
					end else if (port_b.request) begin
						state <= ARB_PORT_B;
						last_b <= 1'b1;
					end
				end
				ARB_PORT_A, ARB_PORT_B: begin
					// Back to idle once the ready pulse has been passed on.
					if (mem.ready) begin
						state <= ARB_IDLE;
					end
				end
				default: begin
					state <= ARB_IDLE;
				end
			endcase
		end
	end

	// Forward the granted port, keep the other one quiet.
	always_comb begin
		mem.request = 1'b0;
		mem.address = '0;
		port_a.ready = 1'b0;
		port_a.rdata = '0;
		port_b.ready = 1'b0;
		port_b.rdata = '0;
		case (state)
			ARB_PORT_A: begin
				mem.request = port_a.request;
				mem.address = port_a.address;
				port_a.ready = mem.ready;
				port_a.rdata = mem.rdata;
			end
			ARB_PORT_B: begin
				mem.request = port_b.request;
				mem.address = port_b.address;
				port_b.ready = mem.ready;
				port_b.rdata = mem.rdata;
			end
			default: begin
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== hw/cache_ram.sv ====
`default_nettype none

module cache_ram import fetch_pkg::*; (
	input  wire         i_clock,
	input  wire set_t   i_rd_set,
	output entry_t      o_rd_entry,
	input  wire         i_wr_enable,
	input  wire set_t   i_wr_set,
	input  wire entry_t i_wr_entry
);

	entry_t mem [SETS];

	// Read port, registered.
	// A write to the same set in this cycle is not seen yet.
	always_ff @(posedge i_clock) begin
		o_rd_entry <= mem[i_rd_set];
	end

	// Write port.
	always_ff @(posedge i_clock) begin
		if (i_wr_enable) begin
			mem[i_wr_set] <= i_wr_entry;
		end
	end

endmodule

`default_nettype wire

// ==== hw/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

	// Fetch address and instruction word.
	typedef logic [31:0] pc_t;
	typedef logic [31:0] word_t;

	// Direct-mapped geometry with one word per line.
	localparam int SET_BITS = 6;
	localparam int SETS = 1 << SET_BITS;
	localparam int TAG_BITS = 30 - SET_BITS;
	localparam int ENTRY_BITS = 1 + TAG_BITS + 32;

	typedef logic [SET_BITS-1:0] set_t;
	typedef logic [TAG_BITS-1:0] tag_t;

	// Valid bit on top, then the tag, then the data word.
	typedef logic [ENTRY_BITS-1:0] entry_t;

	typedef enum logic [1:0] {
		ARB_IDLE,
		ARB_PORT_A,
		ARB_PORT_B
	} arb_state_t;

endpackage

`default_nettype wire

// ==== hw/fetch_top.sv ====
`default_nettype none

module fetch_top import fetch_pkg::*; (
	input  wire         i_clock,
	input  wire         i_reset,
	input  wire pc_t    i_pc_a,
	input  wire pc_t    i_pc_b,
	output wire         o_ready_a,
	output wire         o_ready_b,
	output wire word_t  o_rdata_a,
	output wire word_t  o_rdata_b,
	output wire [31:0]  o_refills_a,
	output wire [31:0]  o_refills_b,
	output wire         o_mem_request,
	output wire pc_t    o_mem_address,
	input  wire         i_mem_ready,
	input  wire word_t  i_mem_rdata
);

	mem_bus_if bus_a ();
	mem_bus_if bus_b ();
	mem_bus_if bus_mem ();

	icache icache_a (
		.i_clock        (i_clock),
		.i_reset        (i_reset),
		.i_pc           (i_pc_a),
		.o_ready        (o_ready_a),
		.o_rdata        (o_rdata_a),
		.o_refill_count (o_refills_a),
		.bus            (bus_a.master)
	);

	icache icache_b (
		.i_clock        (i_clock),
		.i_reset        (i_reset),
		.i_pc           (i_pc_b),
		.o_ready        (o_ready_b),
		.o_rdata        (o_rdata_b),
		.o_refill_count (o_refills_b),
		.bus            (bus_b.master)
	);

	bus_arbiter bus_arbiter_inst (
		.i_clock (i_clock),
		.i_reset (i_reset),
		.port_a  (bus_a.slave),
		.port_b  (bus_b.slave),
		.mem     (bus_mem.master)
	);

	// External memory side.
	assign o_mem_request = bus_mem.request;
	assign o_mem_address = bus_mem.address;
	assign bus_mem.ready = i_mem_ready;
	assign bus_mem.rdata = i_mem_rdata;

endmodule

`default_nettype wire

// ==== hw/icache.sv ====
`default_nettype none

module icache import fetch_pkg::*; (
	input  wire         i_clock,
	input  wire         i_reset,
	input  wire pc_t    i_pc,
	output logic        o_ready,
	output word_t       o_rdata,
	output logic [31:0] o_refill_count,
	mem_bus_if.master   bus
);

	set_t pc_set;
	tag_t pc_tag;

	set_t   rd_set;
	entry_t rd_entry;
	logic   wr_enable;
	set_t   wr_set;
	entry_t wr_entry;

	logic   entry_valid;
	tag_t   entry_tag;
	word_t  entry_data;

	logic              initialized;
	logic [SET_BITS:0] clear_count;
	set_t              last_set;
	logic              fill_settle;
	tag_t              fill_tag;
	logic              miss;
	logic              fill_start;
	logic              fill_done;

	// Index sits just above the byte offset, tag above the index.
	assign pc_set = i_pc[SET_BITS+1:2];
	assign pc_tag = i_pc[31:SET_BITS+2];

	assign entry_valid = rd_entry[ENTRY_BITS-1];
	assign entry_tag = rd_entry[ENTRY_BITS-2 -: TAG_BITS];
	assign entry_data = rd_entry[31:0];

	cache_ram cache_ram_inst (
		.i_clock     (i_clock),
		.i_rd_set    (rd_set),
		.o_rd_entry  (rd_entry),
		.i_wr_enable (wr_enable),
		.i_wr_set    (wr_set),
		.i_wr_entry  (wr_entry)
	);

	// The RAM output belongs to the set presented one cycle earlier.
	always_ff @(posedge i_clock) begin
		last_set <= rd_set;
	end

	// Hit check, with read-ahead of the next set on a hit.
	always_comb begin
		o_ready = 1'b0;
		o_rdata = '0;
		rd_set = '0;
		miss = 1'b0;
		if (initialized) begin
			rd_set = pc_set;
			if (last_set == pc_set) begin
				if (entry_valid && entry_tag == pc_tag) begin
					o_ready = 1'b1;
					o_rdata = entry_data;
					rd_set = pc_set + 1'b1;
				end else begin
					miss = 1'b1;
				end
			end
		end
	end

	// No new refill while one is in flight or its write has not reached a read yet.
	assign fill_start = miss && !bus.request && !wr_enable && !fill_settle;
	assign fill_done = bus.request && bus.ready;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			initialized <= 1'b0;
			clear_count <= '0;
			wr_enable <= 1'b0;
			fill_settle <= 1'b0;
			bus.request <= 1'b0;
			o_refill_count <= '0;
		end else begin
			wr_enable <= 1'b0;
			fill_settle <= wr_enable;
			if (!initialized) begin
				// Clear sweep, one set per cycle.
				if (clear_count < SETS) begin
					wr_enable <= 1'b1;
					clear_count <= clear_count + 1'b1;
				end else begin
					initialized <= 1'b1;
				end
			end else begin
				if (fill_start) begin
					bus.request <= 1'b1;
				end
				if (fill_done) begin
					bus.request <= 1'b0;
					wr_enable <= 1'b1;
					o_refill_count <= o_refill_count + 1'b1;
				end
			end
		end
	end

	// Write payload and bus address.
	always_ff @(posedge i_clock) begin
		if (!initialized) begin
			wr_set <= clear_count[SET_BITS-1:0];
			wr_entry <= '0;
		end else begin
			if (fill_start) begin
				bus.address <= i_pc;
				wr_set <= pc_set;
				fill_tag <= pc_tag;
			end
			if (fill_done) begin
				wr_entry <= {1'b1, fill_tag, bus.rdata};
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/mem_bus_if.sv ====
`default_nettype none

interface mem_bus_if import fetch_pkg::*; ();

	// Request is a level, ready is a single-cycle pulse.
	logic  request;
	pc_t   address;
	logic  ready;
	word_t rdata;

	modport master (
		output request,
		output address,
		input  ready,
		input  rdata
	);

	modport slave (
		input  request,
		input  address,
		output ready,
		output rdata
	);

endinterface

`default_nettype wire

// ==== tb.f ====
hw/fetch_pkg.sv
hw/mem_bus_if.sv
hw/cache_ram.sv
hw/icache.sv
hw/bus_arbiter.sv
hw/fetch_top.sv
bench/mem_model.sv
bench/fetch_asserts.sv
bench/tb_fetch.sv
